/* Bender.yml */
package:
  name: cpu_core

sources:
  - hdl/cpu_pkg.sv
  - hdl/controller.sv
  - hdl/program_rom.sv
  - hdl/program_counter.sv
  - hdl/alu.sv
  - hdl/register_bank.sv
  - hdl/data_memory.sv
  - hdl/io_port.sv
  - hdl/cpu_top.sv
  - target: simulation
    files:
      - sim/cpu_props.sv
      - sim/tb_cpu.sv

/* hdl/alu.sv */
// ----------------------------------------------------------
// ALU, 8-bit, with the status flag register
// ----------------------------------------------------------
`timescale 1ns/10ps

module alu import cpu_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  byte_t   a_val,
    input  byte_t   b_val,
    input  alu_op_t alu_op,
    input  logic    flags_we,
    output byte_t   result,
    output flags_t  flags
);

    logic [8:0] wide;         // Bit 8 is carry or borrow out
    logic       ovf;
    flags_t     next_flags;

    // ----------------------------------------------------------
    // Operations

    always_comb begin
        wide = '0;
        ovf  = 1'b0;
        case (alu_op)
            ALU_PASS_A: wide = {1'b0, a_val};
            ALU_PASS_B: wide = {1'b0, b_val};
            ALU_ADD: begin
                wide = {1'b0, a_val} + {1'b0, b_val};
                ovf  = (a_val[7] == b_val[7]) && (wide[7] != a_val[7]);
            end
            ALU_ADD_CARRY: begin
                wide = {1'b0, a_val} + {1'b0, b_val} + 9'(flags[FLAG_CARRY]);
                ovf  = (a_val[7] == b_val[7]) && (wide[7] != a_val[7]);
            end
            ALU_SUB: begin
                wide = {1'b0, a_val} - {1'b0, b_val};   // Borrow lands in bit 8
                ovf  = (a_val[7] != b_val[7]) && (wide[7] != a_val[7]);
            end
            ALU_AND:    wide = {1'b0, a_val & b_val};
            ALU_OR:     wide = {1'b0, a_val | b_val};
            ALU_XOR:    wide = {1'b0, a_val ^ b_val};
            ALU_NOT_A:  wide = {1'b0, ~a_val};
            ALU_INC_A: begin
                wide = {1'b0, a_val} + 9'd1;
                ovf  = (a_val == 8'h7f);
            end
            ALU_DEC_A: begin
                wide = {1'b0, a_val} - 9'd1;
                ovf  = (a_val == 8'h80);
            end
            ALU_SHL_A: begin
                wide = {a_val, 1'b0};                   // MSB out to carry
                ovf  = a_val[7] ^ a_val[6];             // Sign changed
            end
            ALU_SHR_A:  wide = {a_val[0], 1'b0, a_val[7:1]};
            default:    ;                               // Zero
        endcase
    end

    assign result = wide[7:0];

    // ----------------------------------------------------------
    // Flags

    always_comb begin
        next_flags             = '0;
        next_flags[FLAG_CARRY] = wide[8];
        next_flags[FLAG_ZERO]  = (wide[7:0] == 8'h00);
        next_flags[FLAG_OVF]   = ovf;
        next_flags[FLAG_NEG]   = wide[7];
        // Compare is unsigned and independent of the operation
        next_flags[FLAG_GT]    = (a_val > b_val);
        next_flags[FLAG_LT]    = (a_val < b_val);
        next_flags[FLAG_EQ]    = (a_val == b_val);
        next_flags[FLAG_NE]    = (a_val != b_val);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (flags_we) begin
            flags <= next_flags;
        end
    end

endmodule

/* hdl/controller.sv */
// ----------------------------------------------------------
// Controller
// Splits the microcode word, evaluates the condition, and
// decodes the target device into qualified write enables
// ----------------------------------------------------------
`timescale 1ns/10ps

module controller import cpu_pkg::*; (
    input  instr_t     instr,
    input  flags_t     flags,
    input  logic       di,          // Input byte available
    input  logic       do_ready,    // Output register free
    input  byte_t      marlo,
    output adev_t      a_sel,
    output bdev_t      b_sel,
    output alu_op_t    alu_op,
    output byte_t      immed,
    output byte_t      mem_addr,
    output logic       exec,
    output logic       flags_we,
    output logic [3:0] reg_we,      // a, b, c, d
    output logic       marlo_we,
    output logic       marhi_we,
    output logic       ram_we,
    output logic       out_we,
    output logic       pchitmp_we,
    output logic       pc_we,
    output logic       halt_we
);

    cond_t       cond;
    tdev_t       tdev;
    logic        amode;
    logic        invert;
    logic        set_flags;
    logic [15:0] cond_in;     // One status input per condition code

    // ----------------------------------------------------------
    // Field split

    assign immed     = instr[F_IMMED +: 8];
    assign amode     = instr[F_AMODE];
    assign invert    = instr[F_INVERT];
    assign set_flags = instr[F_SETF];
    assign cond      = cond_t'(instr[F_COND +: 4]);
    assign b_sel     = bdev_t'(instr[F_BDEV +: 3]);
    assign a_sel     = adev_t'(instr[F_ADEV +: 3]);
    assign tdev      = tdev_t'(instr[F_TDEV +: 4]);
    assign alu_op    = alu_op_t'(instr[F_ALU +: 5]);

    // ----------------------------------------------------------
    // Condition

    // Bit 0 always, flags in code order, then DI and DO
    // Top five codes tie low so they never pass
    assign cond_in = {5'b0, do_ready, di, flags, 1'b1};

    assign exec     = cond_in[cond] ^ invert;   // Invert turns "if X" into "unless X"
    assign flags_we = set_flags & exec;

    // Register mode uses marlo, direct mode the instruction address
    assign mem_addr = amode ? instr[F_DADDR +: 8] : marlo;

    // ----------------------------------------------------------
    // Target decode, nothing fires on a failed condition

    always_comb begin
        reg_we     = '0;
        marlo_we   = 1'b0;
        marhi_we   = 1'b0;
        ram_we     = 1'b0;
        out_we     = 1'b0;
        pchitmp_we = 1'b0;
        pc_we      = 1'b0;
        halt_we    = 1'b0;
        if (exec) begin
            case (tdev)
                TDEV_A, TDEV_B,
                TDEV_C, TDEV_D: reg_we[tdev[1:0]] = 1'b1;
                TDEV_MARLO:     marlo_we   = 1'b1;
                TDEV_MARHI:     marhi_we   = 1'b1;
                TDEV_RAM:       ram_we     = 1'b1;
                TDEV_OUT_PORT:  out_we     = 1'b1;
                TDEV_PCHITMP:   pchitmp_we = 1'b1;
                TDEV_PC:        pc_we      = 1'b1;
                TDEV_HALT:      halt_we    = 1'b1;
                default:        ;                   // none
            endcase
        end
    end

endmodule

/* hdl/cpu_pkg.sv */
// ----------------------------------------------------------
// CPU package
// Instruction fields, device and condition codes, ALU ops
// ----------------------------------------------------------
package cpu_pkg;

    // ----------------------------------------------------------
    // Vector types

    typedef logic [7:0]  byte_t;    // Data value
    typedef logic [15:0] addr_t;    // Program or data address
    typedef logic [47:0] instr_t;   // One microcode word
    typedef logic [7:0]  flags_t;   // ALU status, see FLAG_* positions

    // Memory sizes
    localparam int ROM_DEPTH = 256;
    localparam int RAM_DEPTH = 256;

    // ----------------------------------------------------------
    // Field positions in instr_t, LSB of each field

    localparam int F_IMMED  = 0;    // 8 bits
    localparam int F_DADDR  = 8;    // 16 bits, direct address
    localparam int F_AMODE  = 24;   // High selects direct mode
    localparam int F_INVERT = 27;   // Flips the condition result
    localparam int F_SETF   = 28;   // Flag register update
    localparam int F_COND   = 29;   // 4 bits
    localparam int F_BDEV   = 33;   // 3 bits
    localparam int F_ADEV   = 36;   // 3 bits
    localparam int F_TDEV   = 39;   // 4 bits
    localparam int F_ALU    = 43;   // 5 bits

    // Flag bit positions, ordered as condition codes 1 to 8
    localparam int FLAG_CARRY = 0;
    localparam int FLAG_ZERO  = 1;
    localparam int FLAG_OVF   = 2;
    localparam int FLAG_NEG   = 3;
    localparam int FLAG_GT    = 4;
    localparam int FLAG_LT    = 5;
    localparam int FLAG_EQ    = 6;
    localparam int FLAG_NE    = 7;

    // ----------------------------------------------------------
    // Encodings

    typedef enum logic [4:0] {
        ALU_ZERO, ALU_PASS_A, ALU_PASS_B, ALU_ADD, ALU_SUB, ALU_ADD_CARRY, ALU_AND,
        ALU_OR, ALU_XOR, ALU_NOT_A, ALU_INC_A, ALU_DEC_A, ALU_SHL_A, ALU_SHR_A
    } alu_op_t;   // Unlisted codes give zero

    typedef enum logic [2:0] {
        ADEV_A, ADEV_B, ADEV_C, ADEV_D, ADEV_MARLO, ADEV_MARHI, ADEV_IN_PORT, ADEV_ZERO
    } adev_t;

    typedef enum logic [2:0] {
        BDEV_A, BDEV_B, BDEV_C, BDEV_D, BDEV_MARLO, BDEV_MARHI, BDEV_RAM, BDEV_IMMED
    } bdev_t;

    typedef enum logic [3:0] {
        TDEV_A, TDEV_B, TDEV_C, TDEV_D, TDEV_MARLO, TDEV_MARHI, TDEV_RAM, TDEV_OUT_PORT,
        TDEV_PCHITMP, TDEV_PC, TDEV_HALT, TDEV_NONE
    } tdev_t;     // Codes above NONE act as NONE

    typedef enum logic [3:0] {
        COND_ALWAYS, COND_CARRY, COND_ZERO, COND_OVF, COND_NEG, COND_GT, COND_LT,
        COND_EQ, COND_NE, COND_DI, COND_DO, COND_NEVER
    } cond_t;     // Codes above DO never pass

endpackage

/* hdl/cpu_top.sv */
// ----------------------------------------------------------
// CPU top, controller plus datapath blocks
// ----------------------------------------------------------
`timescale 1ns/10ps

module cpu_top import cpu_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    // Program load
    input  logic   prog_we,
    input  byte_t  prog_addr,
    input  instr_t prog_data,
    // Output stream
    output byte_t  out_data,
    output logic   out_valid,
    input  logic   out_ready,
    // Input stream
    input  byte_t  in_data,
    input  logic   in_valid,
    output logic   in_ready,
    // Status
    output addr_t  pc,
    output logic   halted
);

    instr_t     instr;
    flags_t     flags;
    adev_t      a_sel;
    bdev_t      b_sel;
    alu_op_t    alu_op;
    byte_t      immed;
    byte_t      mem_addr;
    byte_t      marlo;
    byte_t      a_val;
    byte_t      b_val;
    byte_t      result;      // ALU output, the only write bus
    byte_t      ram_rdata;
    logic       exec;
    logic       flags_we;
    logic       do_ready;
    logic [3:0] reg_we;
    logic       marlo_we;
    logic       marhi_we;
    logic       ram_we;
    logic       out_we;
    logic       pchitmp_we;
    logic       pc_we;
    logic       halt_we;

    // ----------------------------------------------------------
    // Control

    program_rom u_rom (
        .clk, .prog_we, .prog_addr, .prog_data, .pc, .instr
    );

    controller u_ctrl (
        .instr, .flags, .di(in_valid), .do_ready, .marlo,
        .a_sel, .b_sel, .alu_op, .immed, .mem_addr, .exec, .flags_we,
        .reg_we, .marlo_we, .marhi_we, .ram_we, .out_we,
        .pchitmp_we, .pc_we, .halt_we
    );

    program_counter u_pc (
        .clk, .rst, .pchitmp_we, .pc_we, .halt_we, .result, .pc, .halted
    );

    // ----------------------------------------------------------
    // Datapath

    register_bank u_regs (
        .clk, .rst, .reg_we, .marlo_we, .marhi_we, .result,
        .a_sel, .b_sel, .in_data, .ram_rdata, .immed,
        .a_val, .b_val, .marlo
    );

    alu u_alu (
        .clk, .rst, .a_val, .b_val, .alu_op, .flags_we, .result, .flags
    );

    data_memory u_ram (
        .clk, .ram_we, .mem_addr, .result, .ram_rdata
    );

    io_port u_io (
        .clk, .rst, .out_we, .result, .out_data, .out_valid, .out_ready,
        .do_ready, .a_sel, .exec, .in_valid, .in_ready
    );

endmodule

/* hdl/data_memory.sv */
// ----------------------------------------------------------
// Data RAM, 256 bytes, async read and sync write
// ----------------------------------------------------------
`timescale 1ns/10ps

module data_memory import cpu_pkg::*; (
    input  logic  clk,
    input  logic  ram_we,
    input  byte_t mem_addr,      // Already resolved by address mode
    input  byte_t result,
    output byte_t ram_rdata
);

    byte_t mem [RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (ram_we) begin
            mem[mem_addr] <= result;
        end
    end

    assign ram_rdata = mem[mem_addr];   // Feeds the right operand mux

endmodule

/* hdl/io_port.sv */
// ----------------------------------------------------------
// Byte I/O, output holding register and input consume strobe
// ----------------------------------------------------------
`timescale 1ns/10ps

module io_port import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  out_we,
    input  byte_t result,
    output byte_t out_data,
    output logic  out_valid,
    input  logic  out_ready,
    output logic  do_ready,    // DO flag
    input  adev_t a_sel,
    input  logic  exec,
    input  logic  in_valid,
    output logic  in_ready
);

    // Free when empty or draining this cycle
    assign do_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (out_we && do_ready) begin
            out_data <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (out_we && do_ready) begin
            out_valid <= 1'b1;         // Refill, may overlap a drain
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
        // Write while full and stalled is dropped
    end

    // Consume strobe for the byte the executing instruction reads
    assign in_ready = exec && (a_sel == ADEV_IN_PORT) && in_valid;

endmodule

/* hdl/program_counter.sv */
// ----------------------------------------------------------
// Program counter with pchitmp jump register and halt flag
// ----------------------------------------------------------
`timescale 1ns/10ps

module program_counter import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  pchitmp_we,
    input  logic  pc_we,
    input  logic  halt_we,
    input  byte_t result,
    output addr_t pc,
    output logic  halted
);

    byte_t pchitmp;   // High byte of the next jump

    always_ff @(posedge clk) begin
        if (pchitmp_we) begin
            pchitmp <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (!halted) begin
            if (halt_we) begin
                halted <= 1'b1;                 // pc parks on the halt word
            end else if (pc_we) begin
                pc <= {pchitmp, result};        // Jump
            end else begin
                pc <= pc + 16'd1;
            end
        end
    end

endmodule

/* hdl/program_rom.sv */
// ----------------------------------------------------------
// Program store, 256 x 48, loaded while the core is in reset
// ----------------------------------------------------------
`timescale 1ns/10ps

module program_rom import cpu_pkg::*; (
    input  logic   clk,
    input  logic   prog_we,
    input  byte_t  prog_addr,
    input  instr_t prog_data,
    input  addr_t  pc,
    output instr_t instr
);

    instr_t mem [ROM_DEPTH];

    // Load port
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // Fetch is combinational, only the low byte of pc reaches the store
    assign instr = mem[pc[7:0]];

endmodule

/* hdl/register_bank.sv */
// ----------------------------------------------------------
// Register bank, a b c d plus marlo and marhi
// Also builds the left and right operand muxes
// ----------------------------------------------------------
`timescale 1ns/10ps

module register_bank import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] reg_we,
    input  logic       marlo_we,
    input  logic       marhi_we,
    input  byte_t      result,
    input  adev_t      a_sel,
    input  bdev_t      b_sel,
    input  byte_t      in_data,
    input  byte_t      ram_rdata,
    input  byte_t      immed,
    output byte_t      a_val,
    output byte_t      b_val,
    output byte_t      marlo
);

    byte_t gpr [4];   // a, b, c, d
    byte_t marhi;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                gpr[i] <= '0;
            end
            marlo <= '0;
            marhi <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (reg_we[i]) gpr[i] <= result;
            end
            if (marlo_we) marlo <= result;
            if (marhi_we) marhi <= result;
        end
    end

    // Left operand
    always_comb begin
        case (a_sel)
            ADEV_A:       a_val = gpr[0];
            ADEV_B:       a_val = gpr[1];
            ADEV_C:       a_val = gpr[2];
            ADEV_D:       a_val = gpr[3];
            ADEV_MARLO:   a_val = marlo;
            ADEV_MARHI:   a_val = marhi;
            ADEV_IN_PORT: a_val = in_data;
            default:      a_val = '0;          // zero device
        endcase
    end

    // Right operand
    always_comb begin
        case (b_sel)
            BDEV_A:     b_val = gpr[0];
            BDEV_B:     b_val = gpr[1];
            BDEV_C:     b_val = gpr[2];
            BDEV_D:     b_val = gpr[3];
            BDEV_MARLO: b_val = marlo;
            BDEV_MARHI: b_val = marhi;
            BDEV_RAM:   b_val = ram_rdata;
            default:    b_val = immed;
        endcase
    end

endmodule

/* sim.f */
hdl/cpu_pkg.sv
hdl/controller.sv
hdl/program_rom.sv
hdl/program_counter.sv
hdl/alu.sv
hdl/register_bank.sv
hdl/data_memory.sv
hdl/io_port.sv
hdl/cpu_top.sv
sim/cpu_props.sv
sim/tb_cpu.sv

/* sim/cpu_props.sv */
// ----------------------------------------------------------
// CPU port properties, bound into the top level
// ----------------------------------------------------------
`timescale 1ns/10ps

module cpu_props import cpu_pkg::*; (
    input logic  clk,
    input logic  rst,
    input byte_t out_data,
    input logic  out_valid,
    input logic  out_ready,
    input logic  in_valid,
    input logic  in_ready,
    input addr_t pc,
    input logic  halted
);

    int unsigned fails = 0;

    // Ports come out of reset idle
    assert property (@(posedge clk) rst |=> (!out_valid && !in_ready && !halted))
        else begin $error("Port not idle after reset"); fails++; end

    // Held output byte waits for the sink
    assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else begin $error("out_data changed while stalled"); fails++; end

    // Halt is sticky until reset
    assert property (@(posedge clk) disable iff (rst) halted |=> halted)
        else begin $error("halted dropped without reset"); fails++; end

    assert property (@(posedge clk) disable iff (rst) halted |=> $stable(pc))
        else begin $error("pc moved while halted"); fails++; end

    // Consume strobe only with a byte present
    assert property (@(posedge clk) disable iff (rst) in_ready |-> in_valid)
        else begin $error("in_ready without in_valid"); fails++; end

endmodule

bind cpu_top cpu_props i_props (.*);

/* sim/tb_cpu.sv */
// ----------------------------------------------------------
// CPU testbench
// Loads small programs, models both byte ports, checks output
// ----------------------------------------------------------
`timescale 1ns/10ps

module tb_cpu import cpu_pkg::*; ();

    // Cycle budgets per test, also size the watchdog
    localparam int B_ALU  = 40;
    localparam int B_COND = 60;
    localparam int B_MEM  = 40;
    localparam int B_BP   = 200;
    localparam int B_IN   = 120;
    localparam int B_HALT = 30;
    localparam int BUDGET_SUM  = B_ALU + B_COND + B_MEM + B_BP + B_IN + B_HALT;
    localparam int WATCHDOG_NS = (BUDGET_SUM + 6 * 24) * 10 + 500;   // Load and settle per test

    logic   clk;
    logic   rst;
    logic   prog_we;
    byte_t  prog_addr;
    instr_t prog_data;
    byte_t  out_data;
    logic   out_valid;
    logic   out_ready;
    byte_t  in_data;
    logic   in_valid;
    logic   in_ready;
    addr_t  pc;
    logic   halted;

    instr_t      prog[$];      // Image for the next test
    byte_t       exp_q[$];
    byte_t       got_q[$];     // Bytes taken by the sink
    byte_t       in_q[$];      // Bytes offered on the input port
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          test_start_errs = 0;
    int          in_takes = 0;
    int          rises_after_halt = 0;
    logic        prev_valid = 1'b0;
    logic        bp_mode = 1'b0;   // Random out_ready stalls
    int          stall_cnt = 0;
    int unsigned lcg_state = 43;

    cpu_top i_dut (
        .clk, .rst, .prog_we, .prog_addr, .prog_data,
        .out_data, .out_valid, .out_ready,
        .in_data, .in_valid, .in_ready,
        .pc, .halted
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------------------------
    // Random numbers and instruction assembly

    function automatic int unsigned rand_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) & 32'h7fff;
    endfunction

    function automatic instr_t encode(alu_op_t op, adev_t a, bdev_t b, tdev_t t, cond_t c,
                                      logic inv, logic setf, logic direct, addr_t daddr,
                                      byte_t imm);
        instr_t w;
        w = '0;
        w[F_ALU +: 5]  = op;
        w[F_ADEV +: 3] = a;
        w[F_BDEV +: 3] = b;
        w[F_TDEV +: 4] = t;
        w[F_COND +: 4] = c;
        w[F_INVERT]    = inv;
        w[F_SETF]      = setf;
        w[F_AMODE]     = direct;
        w[F_DADDR +: 16] = daddr;
        w[F_IMMED +: 8]  = imm;
        return w;
    endfunction

    function automatic instr_t alu_word(alu_op_t op, adev_t a, bdev_t b, tdev_t t, logic setf);
        return encode(op, a, b, t, COND_ALWAYS, 1'b0, setf, 1'b0, 16'h0, 8'h0);
    endfunction

    function automatic instr_t load_imm(tdev_t t, byte_t v);
        return encode(ALU_PASS_B, ADEV_ZERO, BDEV_IMMED, t, COND_ALWAYS, 1'b0, 1'b0, 1'b0,
                      16'h0, v);
    endfunction

    function automatic instr_t ram_word(bdev_t b, tdev_t t, logic direct, byte_t addr, byte_t v);
        return encode(ALU_PASS_B, ADEV_ZERO, b, t, COND_ALWAYS, 1'b0, 1'b0, direct,
                      {8'h00, addr}, v);
    endfunction

    // Jump while the condition is false, pchitmp must hold 0
    function automatic instr_t jump_unless(cond_t c, byte_t target);
        return encode(ALU_PASS_B, ADEV_ZERO, BDEV_IMMED, TDEV_PC, c, 1'b1, 1'b0, 1'b0,
                      16'h0, target);
    endfunction

    function automatic instr_t halt_word();
        return encode(ALU_ZERO, ADEV_ZERO, BDEV_IMMED, TDEV_HALT, COND_ALWAYS, 1'b0, 1'b0,
                      1'b0, 16'h0, 8'h0);
    endfunction

    // ----------------------------------------------------------
    // Port models

    always @(posedge clk) begin
        #1;
        if (!bp_mode) begin
            out_ready = 1'b1;
        end else if (stall_cnt > 0) begin
            out_ready = 1'b0;
            stall_cnt--;
        end else begin
            out_ready = 1'b1;                   // One ready cycle, then a new stall
            stall_cnt = rand_next() % 5;
        end
    end

    // Sample mid-cycle, transfers happen at the next rising edge
    always @(negedge clk) begin
        if (!rst) begin
            if (out_valid && out_ready) got_q.push_back(out_data);
            if (in_ready) in_takes++;
            if (halted && out_valid && !prev_valid) rises_after_halt++;
        end
        prev_valid = rst ? 1'b0 : out_valid;
    end

    task automatic feed_inputs();
        int guard;
        @(negedge rst);                         // Core starts running
        foreach (in_q[i]) begin
            repeat (1 + rand_next() % 8) @(posedge clk);
            #1;
            in_data  = in_q[i];
            in_valid = 1'b1;
            guard    = 0;
            do begin
                @(negedge clk);
                guard++;
            end while (!in_ready && guard < 100);
            @(posedge clk);
            #1;
            in_valid = 1'b0;                    // Byte consumed at that edge
        end
    endtask

    // ----------------------------------------------------------
    // Test sequencing

    task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("CHECK FAILED: %s expected 0x%0h got 0x%0h", sig, exp, act);
            errors++;
        end
    endtask

    task automatic run_program(input int budget, input addr_t halt_pc);
        int waited;
        test_start_errs = errors + i_dut.i_props.fails;
        @(posedge clk);
        #1;
        rst = 1'b1;
        got_q.delete();
        in_takes = 0;
        rises_after_halt = 0;
        for (int i = 0; i < prog.size() || i < 4; i++) begin   // At least 4 reset cycles
            prog_we   = (i < prog.size());
            prog_addr = byte_t'(i);
            prog_data = (i < prog.size()) ? prog[i] : '0;
            @(posedge clk);
            #1;
        end
        prog_we = 1'b0;
        rst     = 1'b0;
        waited  = 0;
        while (!(halted && !out_valid) && waited < budget) begin
            @(negedge clk);
            waited++;
        end
        assert (halted && !out_valid) else begin
            $display("Core did not halt and drain within %0d cycles", budget);
            errors++;
        end
        repeat (8) @(negedge clk);              // Nothing may follow the halt
        check_value("out_data count", exp_q.size(), got_q.size());
        foreach (exp_q[i]) begin
            if (i < got_q.size()) check_value("out_data", exp_q[i], got_q[i]);
        end
        check_value("pc", halt_pc, pc);
        check_value("halted", 1, halted);
    endtask

    task automatic report_test(input string name);
        int errs;
        errs = errors + i_dut.i_props.fails - test_start_errs;
        tests++;
        if (errs == 0) $display("%-20s ok, %0d bytes", name, got_q.size());
        else $display("%-20s %0d errors", name, errs);
    endtask

    initial begin
        byte_t va;
        byte_t vb;
        rst       = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        out_ready = 1'b1;
        in_data   = '0;
        in_valid  = 1'b0;
        repeat (4) @(posedge clk);

        // ALU operations on two random operands
        va = byte_t'(rand_next());
        vb = byte_t'(rand_next());
        prog.delete();
        prog.push_back(load_imm(TDEV_A, va));
        prog.push_back(load_imm(TDEV_B, vb));
        prog.push_back(alu_word(ALU_ADD, ADEV_A, BDEV_B, TDEV_OUT_PORT, 1'b0));
        prog.push_back(alu_word(ALU_SUB, ADEV_A, BDEV_B, TDEV_OUT_PORT, 1'b0));
        prog.push_back(alu_word(ALU_AND, ADEV_A, BDEV_B, TDEV_OUT_PORT, 1'b0));
        prog.push_back(alu_word(ALU_XOR, ADEV_A, BDEV_B, TDEV_OUT_PORT, 1'b0));
        prog.push_back(alu_word(ALU_SHL_A, ADEV_A, BDEV_B, TDEV_OUT_PORT, 1'b0));
        prog.push_back(alu_word(ALU_INC_A, ADEV_A, BDEV_B, TDEV_OUT_PORT, 1'b0));
        prog.push_back(halt_word());
        exp_q = {byte_t'(va + vb), byte_t'(va - vb), byte_t'(va & vb), byte_t'(va ^ vb),
                 byte_t'(va << 1), byte_t'(va + 8'd1)};
        run_program(B_ALU, 16'd8);
        report_test("alu_immediates");

        // Countdown loop, branch back unless zero
        prog.delete();
        prog.push_back(load_imm(TDEV_PCHITMP, 8'h00));
        prog.push_back(load_imm(TDEV_A, 8'd5));
        prog.push_back(jump_unless(COND_DO, 8'd2));             // Loop head
        prog.push_back(alu_word(ALU_PASS_A, ADEV_A, BDEV_IMMED, TDEV_OUT_PORT, 1'b0));
        prog.push_back(alu_word(ALU_DEC_A, ADEV_A, BDEV_IMMED, TDEV_A, 1'b1));
        prog.push_back(jump_unless(COND_ZERO, 8'd2));
        prog.push_back(halt_word());
        exp_q.delete();
        for (int v = 5; v >= 1; v--) exp_q.push_back(byte_t'(v));
        run_program(B_COND, 16'd6);
        report_test("cond_invert");

        // Store direct and through marlo, read back the other way
        va = byte_t'(rand_next());
        vb = byte_t'(rand_next());
        prog.delete();
        prog.push_back(ram_word(BDEV_IMMED, TDEV_RAM, 1'b1, 8'h40, va));
        prog.push_back(load_imm(TDEV_MARLO, 8'h41));
        prog.push_back(ram_word(BDEV_IMMED, TDEV_RAM, 1'b0, 8'h00, vb));
        prog.push_back(load_imm(TDEV_MARLO, 8'h40));
        prog.push_back(ram_word(BDEV_RAM, TDEV_OUT_PORT, 1'b0, 8'h00, 8'h00));
        prog.push_back(ram_word(BDEV_RAM, TDEV_OUT_PORT, 1'b1, 8'h41, 8'h00));
        prog.push_back(halt_word());
        exp_q = {va, vb};
        run_program(B_MEM, 16'd6);
        report_test("address_modes");

        // Eight bytes against a stalling sink
        va = byte_t'(rand_next());
        prog.delete();
        prog.push_back(load_imm(TDEV_PCHITMP, 8'h00));
        prog.push_back(load_imm(TDEV_A, va));
        prog.push_back(load_imm(TDEV_C, 8'd8));
        prog.push_back(jump_unless(COND_DO, 8'd3));             // Wait for a free register
        prog.push_back(alu_word(ALU_PASS_A, ADEV_A, BDEV_IMMED, TDEV_OUT_PORT, 1'b0));
        prog.push_back(alu_word(ALU_INC_A, ADEV_A, BDEV_IMMED, TDEV_A, 1'b0));
        prog.push_back(alu_word(ALU_DEC_A, ADEV_C, BDEV_IMMED, TDEV_C, 1'b1));
        prog.push_back(jump_unless(COND_ZERO, 8'd3));
        prog.push_back(halt_word());
        exp_q.delete();
        for (int i = 0; i < 8; i++) exp_q.push_back(byte_t'(va + i));
        bp_mode = 1'b1;
        run_program(B_BP, 16'd8);
        bp_mode = 1'b0;
        report_test("output_backpressure");

        // Poll DI, emit each input byte plus one
        in_q.delete();
        exp_q.delete();
        prog.delete();
        prog.push_back(load_imm(TDEV_PCHITMP, 8'h00));
        for (int k = 0; k < 3; k++) begin
            in_q.push_back(byte_t'(rand_next()));
            exp_q.push_back(byte_t'(in_q[k] + 8'd1));
            prog.push_back(jump_unless(COND_DO, byte_t'(1 + 3 * k)));
            prog.push_back(jump_unless(COND_DI, byte_t'(2 + 3 * k)));
            prog.push_back(alu_word(ALU_INC_A, ADEV_IN_PORT, BDEV_IMMED, TDEV_OUT_PORT, 1'b0));
        end
        prog.push_back(halt_word());
        fork
            run_program(B_IN, 16'd10);
            feed_inputs();
        join
        check_value("in_ready pulses", 3, in_takes);
        report_test("input_polling");

        // Word after the halt must never run
        prog.delete();
        prog.push_back(load_imm(TDEV_OUT_PORT, 8'h77));
        prog.push_back(halt_word());
        prog.push_back(load_imm(TDEV_OUT_PORT, 8'hee));
        exp_q = {8'h77};
        run_program(B_HALT, 16'd1);
        check_value("out_valid rises", 0, rises_after_halt);
        report_test("halt");

        $display("%0d tests, %0d checks, %0d check errors, %0d assertion failures",
                 tests, checks, errors, i_dut.i_props.fails);
        if (errors == 0 && i_dut.i_props.fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run is stuck", WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

endmodule
